//--- verilog.f
hdl/cpu_isa_pkg.sv
hdl/cpu_bus_pkg.sv
hdl/pipe_if.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_core.sv
test/cpu_core_tb.sv

//--- test/cpu_core_tb.sv
`timescale 1ns/10ps

module cpu_core_tb
    import cpu_isa_pkg::*;
();

    localparam int SEED           = 32'h3437;
    localparam int NUM_RANDOM     = 200;
    localparam int TIMEOUT_CYCLES = 4000;           // About 235 instructions at up to 9 cycles

    logic              clk = 1'b0;
    logic              rst;
    logic [DATA_W-1:0] instr;
    logic              instr_valid;
    logic              instr_ready;
    logic [31:0]       paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;

    integer            stim_seed = SEED;            // Instruction stream
    integer            wait_seed = ~SEED;           // Bus wait states
    int                cycles;
    int                data_errs;
    int                proto_errs;
    int                stores_issued;
    int                apb_writes;
    int                wait_left;
    logic [DATA_W-1:0] mem [256];                   // Bus memory model
    logic [DATA_W-1:0] shadow_mem [256];            // Program-order copy
    logic [DATA_W-1:0] shadow [REG_COUNT];          // Register model
    logic [DATA_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [DATA_W-1:0] ea;
    logic [DATA_W-1:0] ed;
    logic [DATA_W-1:0] rand_word;                   // Next random instruction
    logic [3:0]        last_rd;

    cpu_core cpu_core_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready)
    );

    always #50 clk = ~clk;                          // 100 ns period

    function automatic logic [DATA_W-1:0] encode(input opcode_e op, input logic [3:0] rd,
        input logic [3:0] rs1, input logic [3:0] rs2, input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [DATA_W-1:0] sign_extend16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [DATA_W-1:0] alu_expect(input opcode_e op,
        input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // Shadow update in program order, one call per accepted word
    task automatic apply_instr(input logic [DATA_W-1:0] w);
        opcode_e           op;
        logic [3:0]        rd;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] addr;
        op   = opcode_e'(w[OPC_MSB:OPC_LSB]);
        rd   = w[RD_LSB +: 4];
        a    = shadow[w[RS1_LSB +: 4]];             // r0 entry is never written
        b    = shadow[w[RS2_LSB +: 4]];
        addr = a + sign_extend16(w[15:0]);
        case (op)
            ADD, SUB, AND, OR, XOR, SLT:
                if (rd != 0) shadow[rd] = alu_expect(op, a, b);
            ADDI:
                if (rd != 0) shadow[rd] = addr;
            LOAD:
                if (rd != 0) shadow[rd] = shadow_mem[addr[7:0]];  // Low byte picks the word
            STORE:
            begin
                shadow_mem[addr[7:0]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                stores_issued++;
            end
            default: ;
        endcase
    endtask

    task automatic issue(input logic [DATA_W-1:0] word);
        instr       <= word;
        instr_valid <= 1'b1;
        @(posedge clk);
        while (!instr_ready)                        // Held until taken
            @(posedge clk);
    endtask

    // Random op with fields, rs often equal to the last target
    task automatic random_instr(output logic [DATA_W-1:0] word);
        logic [31:0] r;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        opcode_e     op;
        op  = opcode_e'($unsigned($random(stim_seed)) % 10);
        r   = $random(stim_seed);
        rs1 = r[12] ? last_rd : r[7:4];
        rs2 = r[13] ? last_rd : r[11:8];
        word = encode(op, r[3:0], rs1, rs2, r[31:16]);
        if (op != STORE && op != NOP)
            last_rd = r[3:0];
    endtask

    always @(posedge clk)
    begin
        if (!rst && instr_valid && instr_ready)
            apply_instr(instr);
    end

    // APB memory with 0 to 3 wait cycles, stores checked as they complete
    always @(posedge clk)
    begin
        if (rst)
        begin
            pready    <= 1'b0;
            wait_left = 0;
        end
        else if (psel && !penable)
        begin
            wait_left = $unsigned($random(wait_seed)) % 4;
            pready <= (wait_left == 0);
            prdata <= mem[paddr[7:0]];
        end
        else if (psel && penable)
        begin
            if (pready)
            begin
                pready <= 1'b0;
                if (pwrite)
                begin
                    mem[paddr[7:0]] <= pwdata;
                    apb_writes++;
                    if (exp_addr.size() == 0)
                    begin
                        $display("APB write at %0t ns with no store outstanding", $time);
                        data_errs++;
                    end
                    else
                    begin
                        ea = exp_addr.pop_front();
                        ed = exp_data.pop_front();
                        assert (paddr == ea)
                        else
                        begin
                            $display("Fail at %0t ns: store paddr %h, expected %h",
                                     $time, paddr, ea);
                            data_errs++;
                        end
                        assert (pwdata == ed)
                        else
                        begin
                            $display("Fail at %0t ns: store pwdata %h, expected %h",
                                     $time, pwdata, ed);
                            data_errs++;
                        end
                    end
                end
            end
            else
            begin
                if (wait_left == 1)
                    pready <= 1'b1;
                wait_left = wait_left - 1;
            end
        end
    end

    a_setup_to_access: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> psel && penable &&
            $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else
    begin
        $display("Fail at %0t ns: SETUP not followed by a stable ACCESS", $time);
        proto_errs++;
    end

    a_hold_in_wait: assert property (@(posedge clk) disable iff (rst)
        psel && penable && !pready |=> psel && penable &&
            $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else
    begin
        $display("Fail at %0t ns: APB transfer changed before pready", $time);
        proto_errs++;
    end

    a_release_after_done: assert property (@(posedge clk) disable iff (rst)
        psel && penable && pready |=> !penable)
    else
    begin
        $display("Fail at %0t ns: penable still high after completing edge", $time);
        proto_errs++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles, %0d stores still outstanding",
                     cycles, exp_addr.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        prdata      = '0;
        pready      = 1'b0;
        last_rd     = 4'd1;
        for (int k = 0; k < 256; k++)
        begin
            mem[k]        = k * 3;
            shadow_mem[k] = k * 3;
        end
        for (int k = 0; k < REG_COUNT; k++)
            shadow[k] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!psel && !penable && instr_ready)
        else
        begin
            $display("Fail at %0t ns: bus or instr_ready not idle after reset", $time);
            proto_errs++;
        end

        // Seed registers, including negative values
        for (int r = 1; r < REG_COUNT; r++)
            issue(encode(ADDI, r[3:0], 4'd0, 4'd0, 16'(r * 16'h0123 - 16'h0400)));
        issue(encode(ADDI, 4'd0, 4'd5, 4'd0, 16'h0055));   // Aimed at r0
        issue(encode(ADD, 4'd0, 4'd1, 4'd2, 16'h0000));
        issue(encode(STORE, 4'd0, 4'd0, 4'd0, 16'h0020)); // r0 must read zero
        issue(encode(LOAD, 4'd3, 4'd0, 4'd0, 16'h0005));

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            if (($random(stim_seed) & 7) == 0)
            begin
                instr_valid <= 1'b0;                // Occasional bubble
                @(posedge clk);
            end
            random_instr(rand_word);
            issue(rand_word);
        end

        for (int r = 0; r < REG_COUNT; r++)
            issue(encode(STORE, 4'd0, 4'd0, r[3:0], 16'(16'h0080 + r)));
        instr_valid <= 1'b0;

        while (exp_addr.size() != 0)                // Last store marks the end
            @(posedge clk);
        repeat (3) @(posedge clk);
        assert (stores_issued == apb_writes)
        else
        begin
            $display("Fail at %0t ns: %0d stores issued but %0d APB writes",
                     $time, stores_issued, apb_writes);
            data_errs++;
        end

        $display("Errors: data %0d, protocol %0d (stores %0d, APB writes %0d)",
                 data_errs, proto_errs, stores_issued, apb_writes);
        if (data_errs + proto_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/10ps

module cpu_core
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [DATA_W-1:0]  instr,
    input  logic               instr_valid,
    output logic               instr_ready,
    output logic [ADDR_W-1:0]  paddr,
    output logic               psel,
    output logic               penable,
    output logic               pwrite,
    output logic [PDATA_W-1:0] pwdata,
    input  logic [PDATA_W-1:0] prdata,
    input  logic               pready
);

    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic [DATA_W-1:0]     rf_rdata_a;
    logic [DATA_W-1:0]     rf_rdata_b;
    logic                  rf_we;           // Write-back, also clears the scoreboard
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [DATA_W-1:0]     rf_wdata;

    dec_ex_if dx_if ();
    ex_mem_if xm_if ();

    register_file register_file_i (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .rf_raddr_a  (rf_raddr_a),
        .rf_raddr_b  (rf_raddr_b),
        .rf_rdata_a  (rf_rdata_a),
        .rf_rdata_b  (rf_rdata_b),
        .wb_we       (rf_we),
        .wb_addr     (rf_waddr),
        .dx          (dx_if.src)
    );

    execute_stage execute_stage_i (
        .clk (clk),
        .rst (rst),
        .dx  (dx_if.dst),
        .xm  (xm_if.src)
    );

    memory_stage memory_stage_i (
        .clk      (clk),
        .rst      (rst),
        .xm       (xm_if.dst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/10ps

module memory_stage
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    ex_mem_if.dst                 xm,
    output logic [ADDR_W-1:0]     paddr,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [PDATA_W-1:0]    pwdata,
    input  logic [PDATA_W-1:0]    prdata,
    input  logic                  pready,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [DATA_W-1:0]     rf_wdata
);

    apb_state_e state;
    logic       accept;
    logic       mem_op;
    logic       wb_en;                          // Write-back owed when the bus finishes

    assign xm.ready = (state == IDLE);          // One item at a time
    assign accept   = xm.valid && xm.ready;
    assign mem_op   = is_mem(xm.op);

    // APB controls straight from the phase
    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state  <= IDLE;
            pwrite <= 1'b0;
            rf_we  <= 1'b0;
        end
        else
        begin
            rf_we <= 1'b0;                      // Single-cycle pulse
            case (state)
                IDLE:
                    if (accept)
                    begin
                        if (mem_op)
                        begin
                            state  <= SETUP;
                            pwrite <= (xm.op == STORE);
                        end
                        else
                            rf_we <= xm.wr_en;  // ALU result written next cycle
                    end
                SETUP:
                    state <= ACCESS;
                ACCESS:
                    if (pready)
                    begin
                        state <= IDLE;
                        rf_we <= wb_en;         // Load data lands, stores owe nothing
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Address and data held from acceptance to the end of ACCESS
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rf_waddr <= xm.rd;
            wb_en    <= xm.wr_en;
            rf_wdata <= xm.result;
            if (mem_op)
            begin
                paddr  <= xm.result;
                pwdata <= xm.store_data;
            end
        end
        else if (penable && pready)
            rf_wdata <= prdata;                 // Capture read data
    end

    a_setup_first: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel))
    else
        $error("penable rose without a SETUP cycle at %0t", $time);

    a_access_stable: assert property (@(posedge clk) disable iff (rst)
        penable |-> $stable(paddr) && $stable(pwdata) && $stable(pwrite))
    else
        $error("APB address or data moved during ACCESS at %0t", $time);

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
    import cpu_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    dec_ex_if.dst dx,
    ex_mem_if.src xm
);

    logic [DATA_W-1:0] alu_out;
    logic              slt_bit;
    logic              accept;

    // Free when empty or when the memory stage takes the held item
    assign dx.ready = !xm.valid || xm.ready;
    assign accept   = dx.valid && dx.ready;

    assign slt_bit = $signed(dx.opa) < $signed(dx.opb);

    always_comb
    begin
        case (dx.op)
            ADD, ADDI, LOAD, STORE:
                alu_out = dx.opa + dx.opb;      // Sum or effective address
            SUB:
                alu_out = dx.opa - dx.opb;
            AND:
                alu_out = dx.opa & dx.opb;
            OR:
                alu_out = dx.opa | dx.opb;
            XOR:
                alu_out = dx.opa ^ dx.opb;
            SLT:
                alu_out = {{(DATA_W-1){1'b0}}, slt_bit};
            default:
                alu_out = '0;                   // NOP
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            xm.valid <= 1'b0;
        else if (accept)
            xm.valid <= 1'b1;
        else if (xm.ready)
            xm.valid <= 1'b0;                   // Drained, nothing new
    end

    // Output register, held while memory is busy
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            xm.op         <= dx.op;
            xm.rd         <= dx.rd;
            xm.wr_en      <= dx.wr_en;
            xm.result     <= alu_out;
            xm.store_data <= dx.store_data;
        end
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import cpu_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_W-1:0]     instr,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    output logic [REG_ADDR_W-1:0] rf_raddr_a,
    output logic [REG_ADDR_W-1:0] rf_raddr_b,
    input  logic [DATA_W-1:0]     rf_rdata_a,
    input  logic [DATA_W-1:0]     rf_rdata_b,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_addr,
    dec_ex_if.src                 dx
);

    logic [OPC_MSB-OPC_LSB:0] opc_raw;
    opcode_e                  op;
    logic [REG_ADDR_W-1:0]    rd;
    logic [REG_ADDR_W-1:0]    rs1;
    logic [REG_ADDR_W-1:0]    rs2;
    logic                     wr_en;
    logic                     uses_rs1;
    logic                     uses_rs2;
    logic [REG_COUNT-1:0]     pending;          // Scoreboard, one bit per register
    logic [REG_COUNT-1:0]     dx_tgt;           // Target held in the decode register
    logic [REG_COUNT-1:0]     set_mask;
    logic [REG_COUNT-1:0]     clr_mask;
    logic [REG_COUNT-1:0]     busy;
    logic                     hazard;
    logic                     accept;

    // Field split
    assign opc_raw = instr[OPC_MSB:OPC_LSB];
    assign op      = (opc_raw > STORE) ? NOP : opcode_e'(opc_raw);  // Free codes as NOP
    assign rd      = instr[RD_LSB +: REG_ADDR_W];
    assign rs1     = instr[RS1_LSB +: REG_ADDR_W];
    assign rs2     = instr[RS2_LSB +: REG_ADDR_W];

    assign rf_raddr_a = rs1;
    assign rf_raddr_b = rs2;

    // Source use and write intent per opcode
    always_comb
    begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        wr_en    = 1'b1;
        case (op)
            NOP:
            begin
                uses_rs1 = 1'b0;
                wr_en    = 1'b0;
            end
            ADD, SUB, AND, OR, XOR, SLT:
                uses_rs2 = 1'b1;
            STORE:
            begin
                uses_rs2 = 1'b1;                // Store data
                wr_en    = 1'b0;
            end
            default: ;                          // ADDI and LOAD read rs1 only
        endcase
        if (rd == '0)
            wr_en = 1'b0;                       // r0 stays zero
    end

    assign dx_tgt   = (dx.valid && dx.wr_en) ? (REG_COUNT'(1) << dx.rd) : '0;
    assign set_mask = dx.ready ? dx_tgt : '0;   // Marked as it leaves decode
    assign clr_mask = wb_we ? (REG_COUNT'(1) << wb_addr) : '0;

    // A register being written back now is readable through the bypass
    assign busy = (pending & ~clr_mask) | dx_tgt;

    assign hazard = instr_valid &&
                    ((uses_rs1 && busy[rs1]) ||
                     (uses_rs2 && busy[rs2]) ||
                     (wr_en && busy[rd]));      // One writer per register in flight

    assign instr_ready = !hazard && (!dx.valid || dx.ready);
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dx.valid <= 1'b0;
            pending  <= '0;
        end
        else
        begin
            pending <= (pending & ~clr_mask) | set_mask;  // Set wins on a collision
            if (accept)
                dx.valid <= 1'b1;
            else if (dx.ready)
                dx.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dx.op         <= op;
            dx.rd         <= rd;
            dx.wr_en      <= wr_en;
            dx.opa        <= rf_rdata_a;
            dx.opb        <= uses_imm(op) ? sext_imm(instr[IMM_W-1:0]) : rf_rdata_b;
            dx.store_data <= rf_rdata_b;
        end
    end

    a_dx_hold: assert property (@(posedge clk) disable iff (rst)
        dx.valid && !dx.ready |=> dx.valid &&
            $stable({dx.op, dx.rd, dx.wr_en, dx.opa, dx.opb, dx.store_data}))
    else
        $error("decode output changed while stalled at %0t", $time);

endmodule

//--- hdl/register_file.sv
`timescale 1ns/10ps

module register_file
    import cpu_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] raddr_a,
    input  logic [REG_ADDR_W-1:0] raddr_b,
    output logic [DATA_W-1:0]     rdata_a,
    output logic [DATA_W-1:0]     rdata_b,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0]     wdata
);

    logic [DATA_W-1:0] regs [REG_COUNT];

    // Same-cycle write shows through, r0 is hard zero
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (we && (waddr == addr))
            return wdata;                       // Bypass
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we && (waddr != '0))           // r0 never stored
            regs[waddr] <= wdata;
    end

    always_comb
    begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

    // Decode drops wr_en for rd 0, so write-back never targets it
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        we |-> (waddr != '0))
    else
        $error("write-back aimed at r0 at %0t", $time);

endmodule

//--- hdl/pipe_if.sv
`timescale 1ns/10ps

// Decode to execute link
interface dec_ex_if
    import cpu_isa_pkg::*;
();

    logic                  valid;               // Item present
    logic                  ready;               // Execute can take it
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;                  // Write-back target
    logic                  wr_en;               // Low for STORE, NOP and rd 0
    logic [DATA_W-1:0]     opa;                 // rs1 value
    logic [DATA_W-1:0]     opb;                 // rs2 value or immediate
    logic [DATA_W-1:0]     store_data;          // rs2 value for STORE

    modport src (
        output valid, op, rd, wr_en, opa, opb, store_data,
        input  ready
    );

    modport dst (
        input  valid, op, rd, wr_en, opa, opb, store_data,
        output ready
    );

endinterface

// Execute to memory link
interface ex_mem_if
    import cpu_isa_pkg::*;
();

    logic                  valid;
    logic                  ready;               // Low while the APB master is busy
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wr_en;
    logic [DATA_W-1:0]     result;              // ALU value or bus address
    logic [DATA_W-1:0]     store_data;

    modport src (
        output valid, op, rd, wr_en, result, store_data,
        input  ready
    );

    modport dst (
        input  valid, op, rd, wr_en, result, store_data,
        output ready
    );

endinterface

//--- hdl/cpu_bus_pkg.sv
package cpu_bus_pkg;

    import cpu_isa_pkg::*;

    localparam int ADDR_W  = 32;                // APB byte address
    localparam int PDATA_W = DATA_W;            // Bus data follows the core word

    // APB master phases
    // IDLE    psel low, free for a new request
    // SETUP   psel high, penable low, one cycle only
    // ACCESS  psel and penable high until pready
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } apb_state_e;

endpackage

//--- hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int DATA_W     = 32;             // Machine word
    localparam int REG_COUNT  = 16;             // Architectural registers
    localparam int REG_ADDR_W = 4;              // Register index width

    // Instruction word layout, msb first
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int RD_LSB  = 24;                // rd in 27:24
    localparam int RS1_LSB = 20;                // rs1 in 23:20, base for LOAD/STORE
    localparam int RS2_LSB = 16;                // rs2 in 19:16, data for STORE
    localparam int IMM_W   = 16;                // Signed immediate in 15:0

    // Codes above STORE are free and decode as NOP
    typedef enum logic [OPC_MSB-OPC_LSB:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        XOR   = 4'd5,
        SLT   = 4'd6,                           // Signed compare
        ADDI  = 4'd7,
        LOAD  = 4'd8,
        STORE = 4'd9
    } opcode_e;

    function automatic logic [DATA_W-1:0] sext_imm(input logic [IMM_W-1:0] imm);
        return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    // Operand b comes from the immediate for these
    function automatic logic uses_imm(input opcode_e op);
        return (op == ADDI) || (op == LOAD) || (op == STORE);
    endfunction

    function automatic logic is_mem(input opcode_e op);
        return (op == LOAD) || (op == STORE);   // Goes out on the data bus
    endfunction

endpackage
